//--- rtl/procPkg.sv
// ISA widths, opcode and forwarding encodings, pipeline register structs
`default_nettype none

package procPkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;

   // Unlisted opcode values are illegal
   typedef enum logic [3:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      AND  = 4'd2,
      XOR  = 4'd3,
      ADDI = 4'd4,
      LD   = 4'd5,
      ST   = 4'd6,
      BEQZ = 4'd7,
      HALT = 4'd15
   } opcode_e;

   typedef enum logic [1:0] {
      REG      = 2'd0,
      FROM_EM  = 2'd1,
      FROM_RET = 2'd2
   } fwdSel_e;

   typedef struct packed {
      opcode_e opcode;
      logic    useImm;
      logic    memRd;
      logic    memWr;
      logic    regWr;
      logic    isBranch;
      logic    isHalt;
      regIdx_t rd;
   } ctrl_t;

   typedef struct packed {
      logic    valid;
      ctrl_t   ctrl;
      word_t   pc;
      regIdx_t rs;
      regIdx_t rt;
      word_t   rsVal;
      word_t   rtVal;
      word_t   rdVal;
      word_t   imm;
   } deReg_t;

   typedef struct packed {
      logic  valid;
      ctrl_t ctrl;
      word_t result;
      word_t storeData;
   } emReg_t;

   typedef struct packed {
      logic    valid;
      logic    regWr;
      regIdx_t rd;
      word_t   data;
      logic    isHalt;
   } retire_t;

endpackage

`default_nettype wire

//--- rtl/regFile.sv
// Eight-entry register file, three read ports, one write port with write-through
`timescale 1ns/10ps
`default_nettype none

module regFile (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire procPkg::regIdx_t  rdIdxA,
   input  wire procPkg::regIdx_t  rdIdxB,
   input  wire procPkg::regIdx_t  rdIdxC,
   output procPkg::word_t         rdValA,
   output procPkg::word_t         rdValB,
   output procPkg::word_t         rdValC,
   input  wire procPkg::retire_t  wrPort
);

   procPkg::word_t regs [0:7];
   logic           wrEn;

   assign wrEn = wrPort.valid && wrPort.regWr;

   // Retiring value is visible in the same cycle
   assign rdValA = (wrEn && wrPort.rd == rdIdxA) ? wrPort.data : regs[rdIdxA];
   assign rdValB = (wrEn && wrPort.rd == rdIdxB) ? wrPort.data : regs[rdIdxB];
   assign rdValC = (wrEn && wrPort.rd == rdIdxC) ? wrPort.data : regs[rdIdxC];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrPort.rd] <= wrPort.data;
      end
   end

endmodule

`default_nettype wire

//--- rtl/fetch.sv
// Program counter and fetch/decode register
`timescale 1ns/10ps
`default_nettype none

module fetch #(
   parameter procPkg::word_t ResetPc = 16'h0000
) (
   input  wire                  clk,
   input  wire                  rstN,
   input  wire                  stallFront,
   input  wire                  flush,
   input  wire                  haltSeen,
   input  wire                  redirect,
   input  wire procPkg::word_t  target,
   output procPkg::word_t       imemAddr,
   input  wire procPkg::word_t  imemData,
   output logic                 fdValid,
   output procPkg::word_t       fdInstr,
   output procPkg::word_t       fdPc
);

   procPkg::word_t pc;

   assign imemAddr = pc;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc      <= ResetPc;
         fdValid <= 1'b0;
      end else if (!stallFront) begin
         // Redirect wins over the halt hold
         if (redirect) begin
            pc <= target;
         end else if (!haltSeen) begin
            pc <= pc + 16'd1;
         end
         fdValid <= !flush && !haltSeen;
      end
   end

   always_ff @(posedge clk) begin
      if (!stallFront) begin
         fdInstr <= imemData;
         fdPc    <= pc;
      end
   end

endmodule

`default_nettype wire

//--- rtl/decode.sv
// Instruction decode, register read and decode/execute register
`timescale 1ns/10ps
`default_nettype none

module decode (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire                    fdValid,
   input  wire procPkg::word_t    fdInstr,
   input  wire procPkg::word_t    fdPc,
   input  wire                    stallFront,
   input  wire                    bubbleDe,
   input  wire                    memStall,
   input  wire                    flush,
   input  wire procPkg::retire_t  retireIn,
   output procPkg::regIdx_t       srcRs,
   output procPkg::regIdx_t       srcRt,
   output logic                   haltSeen,
   output procPkg::deReg_t        deOut,
   output logic                   err
);

   procPkg::regIdx_t fRd;
   procPkg::regIdx_t fRs;
   procPkg::regIdx_t fRt;
   procPkg::word_t   imm;
   procPkg::ctrl_t   ctrl;
   logic             illegal;
   procPkg::regIdx_t idxA;
   procPkg::regIdx_t idxB;
   procPkg::regIdx_t idxC;
   procPkg::word_t   valA;
   procPkg::word_t   valB;
   procPkg::word_t   valC;
   logic             haltLatched;
   logic             takeFd;

   assign fRd = fdInstr[11:9];
   assign fRs = fdInstr[8:6];
   assign fRt = fdInstr[5:3];
   assign imm = {{10{fdInstr[5]}}, fdInstr[5:0]};

   always_comb begin
      ctrl        = '0;
      ctrl.opcode = procPkg::opcode_e'(fdInstr[15:12]);
      ctrl.rd     = fRd;
      illegal     = 1'b0;
      case (ctrl.opcode)
         procPkg::ADD, procPkg::SUB, procPkg::AND, procPkg::XOR: ctrl.regWr = 1'b1;
         procPkg::ADDI: begin
            ctrl.useImm = 1'b1;
            ctrl.regWr  = 1'b1;
         end
         procPkg::LD: begin
            ctrl.useImm = 1'b1;
            ctrl.memRd  = 1'b1;
            ctrl.regWr  = 1'b1;
         end
         procPkg::ST: begin
            ctrl.useImm = 1'b1;
            ctrl.memWr  = 1'b1;
         end
         procPkg::BEQZ: ctrl.isBranch = 1'b1;
         procPkg::HALT: ctrl.isHalt = 1'b1;
         // No control bits set, so it passes through as a no-op
         default: illegal = 1'b1;
      endcase
   end

   // Store data comes from rd, so it counts as the second source
   assign srcRs = fRs;
   assign srcRt = ctrl.memWr ? fRd : fRt;

   // While held, re-read the operands of the instruction waiting in execute
   assign idxA = memStall ? deOut.rs : fRs;
   assign idxB = memStall ? deOut.rt : fRt;
   assign idxC = memStall ? deOut.ctrl.rd : fRd;

   regFile regFile_i (
      .clk    (clk),
      .rstN   (rstN),
      .rdIdxA (idxA),
      .rdIdxB (idxB),
      .rdIdxC (idxC),
      .rdValA (valA),
      .rdValB (valB),
      .rdValC (valC),
      .wrPort (retireIn)
   );

   assign takeFd   = fdValid && !stallFront && !flush;
   assign haltSeen = haltLatched || (fdValid && ctrl.isHalt);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         deOut <= '0;
      end else if (memStall) begin
         deOut.rsVal <= valA;
         deOut.rtVal <= valB;
         deOut.rdVal <= valC;
      end else if (bubbleDe || flush) begin
         deOut.valid <= 1'b0;
      end else begin
         deOut.valid <= fdValid;
         deOut.ctrl  <= ctrl;
         deOut.pc    <= fdPc;
         deOut.rs    <= fRs;
         deOut.rt    <= fRt;
         deOut.rsVal <= valA;
         deOut.rtVal <= valB;
         deOut.rdVal <= valC;
         deOut.imm   <= imm;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         haltLatched <= 1'b0;
         err         <= 1'b0;
      end else begin
         if (takeFd && ctrl.isHalt) begin
            haltLatched <= 1'b1;
         end
         if (takeFd && illegal) begin
            err <= 1'b1;
         end
      end
   end

   errSticky_a : assert property (@(posedge clk) disable iff (!rstN) err |=> err);

endmodule

`default_nettype wire

//--- rtl/hazardCtrl.sv
// Load-use and memory stalls, branch flush, forwarding selects
`timescale 1ns/10ps
`default_nettype none

module hazardCtrl (
   input  wire                    clk,
   input  wire procPkg::regIdx_t  srcRs,
   input  wire procPkg::regIdx_t  srcRt,
   input  wire                    fdValid,
   input  wire procPkg::deReg_t   deIn,
   input  wire procPkg::emReg_t   emIn,
   input  wire procPkg::retire_t  retireIn,
   input  wire                    branchTaken,
   input  wire                    memBusy,
   output logic                   stallFront,
   output logic                   bubbleDe,
   output logic                   memStall,
   output logic                   flush,
   output procPkg::fwdSel_e       fwdA,
   output procPkg::fwdSel_e       fwdB
);

   logic             loadUse;
   procPkg::regIdx_t srcB;

   function automatic procPkg::fwdSel_e pickSrc(
      procPkg::regIdx_t src,
      procPkg::emReg_t  em,
      procPkg::retire_t ret
   );
      if (em.valid && em.ctrl.regWr && em.ctrl.rd == src) begin
         return procPkg::FROM_EM;
      end else if (ret.valid && ret.regWr && ret.rd == src) begin
         return procPkg::FROM_RET;
      end
      return procPkg::REG;
   endfunction

   assign loadUse = fdValid && deIn.valid && deIn.ctrl.memRd &&
                    (srcRs == deIn.ctrl.rd || srcRt == deIn.ctrl.rd);

   // Memory stall first, then load-use
   assign memStall   = memBusy;
   assign stallFront = memBusy || loadUse;
   assign bubbleDe   = loadUse && !memBusy;
   assign flush      = branchTaken && !memBusy;

   // A store's second operand is its rd
   assign srcB = deIn.ctrl.memWr ? deIn.ctrl.rd : deIn.rt;
   assign fwdA = pickSrc(deIn.rs, emIn, retireIn);
   assign fwdB = pickSrc(srcB, emIn, retireIn);

   // A bubble and a flush never hit the same cycle
   stallExclusive_a : assert property (@(posedge clk) bubbleDe |-> !flush);

   // The load-use stall keeps a load out of the forwarding path
   noLoadFwd_a : assert property (@(posedge clk)
      deIn.valid && emIn.valid && emIn.ctrl.memRd |->
         fwdA != procPkg::FROM_EM && fwdB != procPkg::FROM_EM);

endmodule

`default_nettype wire

//--- rtl/execute.sv
// Operand forwarding, ALU, branch resolution and execute/memory register
`timescale 1ns/10ps
`default_nettype none

module execute (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire procPkg::deReg_t   deIn,
   input  wire                    memStall,
   input  wire procPkg::fwdSel_e  fwdA,
   input  wire procPkg::fwdSel_e  fwdB,
   input  wire procPkg::retire_t  retireIn,
   output procPkg::emReg_t        emOut,
   output logic                   branchTaken,
   output procPkg::word_t         target
);

   procPkg::word_t aVal;
   procPkg::word_t bVal;
   procPkg::word_t opB;
   procPkg::word_t result;

   function automatic procPkg::word_t pickVal(
      procPkg::fwdSel_e sel,
      procPkg::word_t   regVal,
      procPkg::word_t   emVal,
      procPkg::word_t   retVal
   );
      case (sel)
         procPkg::FROM_EM:  return emVal;
         procPkg::FROM_RET: return retVal;
         default:           return regVal;
      endcase
   endfunction

   assign aVal = pickVal(fwdA, deIn.rsVal, emOut.result, retireIn.data);
   // rdVal is the store data, rtVal the second ALU operand
   assign bVal = pickVal(fwdB, deIn.ctrl.memWr ? deIn.rdVal : deIn.rtVal,
                         emOut.result, retireIn.data);
   assign opB  = deIn.ctrl.useImm ? deIn.imm : bVal;

   always_comb begin
      case (deIn.ctrl.opcode)
         procPkg::SUB: result = aVal - opB;
         procPkg::AND: result = aVal & opB;
         procPkg::XOR: result = aVal ^ opB;
         // ADD, ADDI and the LD/ST address
         default:      result = aVal + opB;
      endcase
   end

   assign branchTaken = deIn.valid && deIn.ctrl.isBranch && (aVal == '0);
   assign target      = deIn.pc + 16'd1 + deIn.imm;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         emOut <= '0;
      end else if (!memStall) begin
         emOut.valid     <= deIn.valid;
         emOut.ctrl      <= deIn.ctrl;
         emOut.result    <= result;
         emOut.storeData <= bVal;
      end
   end

endmodule

`default_nettype wire

//--- rtl/memStage.sv
// Data port FSM, load data capture and retire register
`timescale 1ns/10ps
`default_nettype none

module memStage (
   input  wire                   clk,
   input  wire                   rstN,
   input  wire procPkg::emReg_t  emIn,
   output logic                  dmemReq,
   output logic                  dmemWe,
   output procPkg::word_t        dmemAddr,
   output procPkg::word_t        dmemWdata,
   input  wire procPkg::word_t   dmemRdata,
   input  wire                   dmemDone,
   output logic                  memBusy,
   output procPkg::retire_t      retireOut,
   output logic                  halted
);

   typedef enum logic {
      IDLE,
      WAIT
   } memState_e;

   memState_e state;
   logic      isAccess;

   assign isAccess  = emIn.valid && (emIn.ctrl.memRd || emIn.ctrl.memWr);
   assign dmemReq   = (state == WAIT);
   assign dmemWe    = emIn.ctrl.memWr;
   assign dmemAddr  = emIn.result;
   assign dmemWdata = emIn.storeData;

   // Busy until the done pulse, the pipe moves on that edge
   assign memBusy = isAccess && !(state == WAIT && dmemDone);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:    if (isAccess) state <= WAIT;
            WAIT:    if (dmemDone) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         retireOut <= '0;
         halted    <= 1'b0;
      end else if (memBusy) begin
         retireOut.valid <= 1'b0;
      end else begin
         retireOut.valid  <= emIn.valid;
         retireOut.regWr  <= emIn.ctrl.regWr;
         retireOut.rd     <= emIn.ctrl.rd;
         retireOut.data   <= emIn.ctrl.memRd ? dmemRdata : emIn.result;
         retireOut.isHalt <= emIn.ctrl.isHalt;
         if (emIn.valid && emIn.ctrl.isHalt) begin
            halted <= 1'b1;
         end
      end
   end

   addrStable_a : assert property (@(posedge clk) disable iff (!rstN)
      dmemReq && !dmemDone |=> $stable(dmemAddr));

endmodule

`default_nettype wire

//--- rtl/proc.sv
// Pipelined processor top level
`timescale 1ns/10ps
`default_nettype none

module proc #(
   parameter procPkg::word_t ResetPc = 16'h0000
) (
   input  wire                   clk,
   input  wire                   rstN,
   output procPkg::word_t        imemAddr,
   input  wire procPkg::word_t   imemData,
   output logic                  dmemReq,
   output logic                  dmemWe,
   output procPkg::word_t        dmemAddr,
   output procPkg::word_t        dmemWdata,
   input  wire procPkg::word_t   dmemRdata,
   input  wire                   dmemDone,
   output procPkg::retire_t      retireOut,
   output logic                  halted,
   output logic                  err
);

   wire                   fdValid;
   wire procPkg::word_t   fdInstr;
   wire procPkg::word_t   fdPc;
   wire                   stallFront;
   wire                   bubbleDe;
   wire                   memStall;
   wire                   flush;
   wire                   haltSeen;
   wire                   branchTaken;
   wire procPkg::word_t   target;
   wire procPkg::regIdx_t srcRs;
   wire procPkg::regIdx_t srcRt;
   wire procPkg::deReg_t  deReg;
   wire procPkg::emReg_t  emReg;
   wire                   memBusy;
   wire procPkg::fwdSel_e fwdA;
   wire procPkg::fwdSel_e fwdB;

   fetch #(.ResetPc(ResetPc)) fetch_i (
      .clk        (clk),
      .rstN       (rstN),
      .stallFront (stallFront),
      .flush      (flush),
      .haltSeen   (haltSeen),
      .redirect   (branchTaken),
      .target     (target),
      .imemAddr   (imemAddr),
      .imemData   (imemData),
      .fdValid    (fdValid),
      .fdInstr    (fdInstr),
      .fdPc       (fdPc)
   );

   decode decode_i (
      .clk        (clk),
      .rstN       (rstN),
      .fdValid    (fdValid),
      .fdInstr    (fdInstr),
      .fdPc       (fdPc),
      .stallFront (stallFront),
      .bubbleDe   (bubbleDe),
      .memStall   (memStall),
      .flush      (flush),
      .retireIn   (retireOut),
      .srcRs      (srcRs),
      .srcRt      (srcRt),
      .haltSeen   (haltSeen),
      .deOut      (deReg),
      .err        (err)
   );

   hazardCtrl hazardCtrl_i (
      .clk         (clk),
      .srcRs       (srcRs),
      .srcRt       (srcRt),
      .fdValid     (fdValid),
      .deIn        (deReg),
      .emIn        (emReg),
      .retireIn    (retireOut),
      .branchTaken (branchTaken),
      .memBusy     (memBusy),
      .stallFront  (stallFront),
      .bubbleDe    (bubbleDe),
      .memStall    (memStall),
      .flush       (flush),
      .fwdA        (fwdA),
      .fwdB        (fwdB)
   );

   execute execute_i (
      .clk         (clk),
      .rstN        (rstN),
      .deIn        (deReg),
      .memStall    (memStall),
      .fwdA        (fwdA),
      .fwdB        (fwdB),
      .retireIn    (retireOut),
      .emOut       (emReg),
      .branchTaken (branchTaken),
      .target      (target)
   );

   memStage memStage_i (
      .clk       (clk),
      .rstN      (rstN),
      .emIn      (emReg),
      .dmemReq   (dmemReq),
      .dmemWe    (dmemWe),
      .dmemAddr  (dmemAddr),
      .dmemWdata (dmemWdata),
      .dmemRdata (dmemRdata),
      .dmemDone  (dmemDone),
      .memBusy   (memBusy),
      .retireOut (retireOut),
      .halted    (halted)
   );

endmodule

`default_nettype wire

//--- tests/tbProc.sv
// Processor testbench with clock, memory models, ISA model, checks and report
`timescale 1ns/10ps
`default_nettype none

module tbProc;

   logic             clk;
   logic             rstN;
   procPkg::word_t   imemAddr;
   procPkg::word_t   imemData;
   logic             dmemReq;
   logic             dmemWe;
   procPkg::word_t   dmemAddr;
   procPkg::word_t   dmemWdata;
   procPkg::word_t   dmemRdata;
   logic             dmemDone;
   procPkg::retire_t retireOut;
   logic             halted;
   logic             err;

   procPkg::word_t imem [0:255];
   procPkg::word_t dmem [0:63];
   procPkg::word_t mdlMem [0:63];
   // Expected register writes as {rd, data}
   logic [18:0]    expQ [$];
   int             expRetires;
   logic           expErr;
   logic [31:0]    rngState = 32'h037b3976;
   int             waitLeft;
   int             errors;
   int             checks;
   int             testsRun;
   int             testsFailed;
   bit             timedOut;

   proc #(.ResetPc(16'h0000)) dut_i (
      .clk       (clk),
      .rstN      (rstN),
      .imemAddr  (imemAddr),
      .imemData  (imemData),
      .dmemReq   (dmemReq),
      .dmemWe    (dmemWe),
      .dmemAddr  (dmemAddr),
      .dmemWdata (dmemWdata),
      .dmemRdata (dmemRdata),
      .dmemDone  (dmemDone),
      .retireOut (retireOut),
      .halted    (halted),
      .err       (err)
   );

   assign imemData = imem[imemAddr[7:0]];

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] nextRand();
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return rngState >> 8;
   endfunction

   function automatic procPkg::word_t fillWord(input int addr);
      return 16'(addr * 40503) ^ 16'h5a3c;
   endfunction

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Fail %0t %s got %0h expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Data memory, each request answered after 0 to 3 wait cycles
   initial begin
      forever begin
         @(posedge clk);
         #1;
         if (dmemDone) begin
            dmemDone = 1'b0;
         end else if (dmemReq) begin
            if (waitLeft < 0) begin
               waitLeft = nextRand() % 4;
            end
            if (waitLeft == 0) begin
               if (dmemWe) begin
                  dmem[dmemAddr[5:0]] = dmemWdata;
               end else begin
                  dmemRdata = dmem[dmemAddr[5:0]];
               end
               dmemDone = 1'b1;
            end
            waitLeft--;
         end
      end
   end

   task automatic genProgram(input int kind, input int n);
      logic [3:0] op;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [5:0] low;
      int         span;
      // Unused words decode as HALT
      for (int i = 0; i < 256; i++) begin
         imem[i] = {4'hF, 12'(i)};
      end
      for (int i = 0; i < n - 1; i++) begin
         rd  = nextRand() % 8;
         rs  = nextRand() % 8;
         low = nextRand() % 64;
         case (kind)
            0:       op = nextRand() % 5;
            1:       op = (nextRand() % 2) ? 4'd5 + nextRand() % 2 : nextRand() % 5;
            2:       op = (nextRand() % 3 == 0) ? 4'd7 : nextRand() % 5;
            3:       op = nextRand() % 8;
            default: op = nextRand() % 7;
         endcase
         if (op == 4'd7) begin
            // Forward offset that stays inside the program
            span = n - 2 - i;
            if (span > 7) begin
               span = 7;
            end
            low = nextRand() % (span + 1);
            if (kind == 2 && nextRand() % 2) begin
               rs = 3'd0;
            end
         end else if (kind == 2) begin
            rd = 3'd1 + nextRand() % 7;
         end
         imem[i] = {op, rd, rs, low};
      end
      imem[n - 1] = 16'hF000;
      if (kind == 4) begin
         imem[n / 2] = {4'd8 + 4'(nextRand() % 7), 12'(nextRand())};
      end
   endtask

   // ISA interpreter
   task automatic runModel();
      procPkg::word_t regs [0:7];
      procPkg::word_t instr;
      procPkg::word_t imm;
      procPkg::word_t a;
      procPkg::word_t b;
      procPkg::word_t addr;
      procPkg::word_t val;
      procPkg::word_t pc;
      logic [2:0]     rd;
      bit             wr;
      bit             done;
      expQ.delete();
      expRetires = 0;
      expErr     = 1'b0;
      pc         = '0;
      done       = 1'b0;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < 64; i++) begin
         mdlMem[i] = fillWord(i);
      end
      while (!done && expRetires < 4096) begin
         instr = imem[pc[7:0]];
         rd    = instr[11:9];
         a     = regs[instr[8:6]];
         b     = regs[instr[5:3]];
         imm   = {{10{instr[5]}}, instr[5:0]};
         addr  = a + imm;
         wr    = 1'b0;
         pc    = pc + 16'd1;
         expRetires++;
         case (instr[15:12])
            4'd0:  {wr, val} = {1'b1, a + b};
            4'd1:  {wr, val} = {1'b1, a - b};
            4'd2:  {wr, val} = {1'b1, a & b};
            4'd3:  {wr, val} = {1'b1, a ^ b};
            4'd4:  {wr, val} = {1'b1, addr};
            4'd5:  {wr, val} = {1'b1, mdlMem[addr[5:0]]};
            4'd6:  mdlMem[addr[5:0]] = regs[rd];
            4'd7: begin
               if (a == '0) begin
                  pc = pc + imm;
               end
            end
            4'd15:   done = 1'b1;
            default: expErr = 1'b1;
         endcase
         if (wr) begin
            regs[rd] = val;
            expQ.push_back({rd, val});
         end
      end
   endtask

   task automatic resetDut();
      @(posedge clk);
      #1;
      rstN     = 1'b0;
      dmemDone = 1'b0;
      waitLeft = -1;
      for (int i = 0; i < 64; i++) begin
         dmem[i] = fillWord(i);
      end
      repeat (5) @(posedge clk);
      #1;
      rstN = 1'b1;
   endtask

   task automatic runTest(input string name, input int kind, input int n);
      procPkg::retire_t r;
      logic [18:0]      exp;
      int               cycles;
      int               retires;
      int               limit;
      int               errBefore;
      bit               haltDone;
      bit               errHigh;
      errBefore = errors;
      genProgram(kind, n);
      runModel();
      resetDut();
      limit    = n * 8 + 200;
      cycles   = 0;
      retires  = 0;
      haltDone = 1'b0;
      errHigh  = 1'b0;
      while (!haltDone && cycles < limit) begin
         @(negedge clk);
         cycles++;
         r = retireOut;
         if (errHigh && !err) begin
            $display("err went low at %0t without a reset", $time);
            errors++;
         end
         errHigh = errHigh || err;
         if (r.valid) begin
            retires++;
            if (r.regWr && expQ.size() == 0) begin
               $display("Unexpected register write to r%0d at %0t", r.rd, $time);
               errors++;
            end else if (r.regWr) begin
               exp = expQ.pop_front();
               checkEq("retireOut.rd", r.rd, exp[18:16]);
               checkEq("retireOut.data", r.data, exp[15:0]);
            end
            // The HALT is the last instruction the model runs
            checkEq("retireOut.isHalt", r.isHalt, retires == expRetires);
            haltDone = r.isHalt;
         end
         checkEq("halted", halted, retires == expRetires);
      end
      if (!haltDone) begin
         $display("Timeout: %s did not retire its HALT within %0d cycles", name, limit);
         errors++;
         timedOut = 1'b1;
      end else begin
         checkEq("pending writes", expQ.size(), 0);
         checkEq("retired count", retires, expRetires);
         repeat (10) begin
            @(negedge clk);
            if (retireOut.valid) begin
               $display("An instruction retired after HALT at %0t", $time);
               errors++;
            end
            checkEq("halted", halted, 1);
         end
         for (int i = 0; i < 64; i++) begin
            checkEq($sformatf("dmem[%0d]", i), dmem[i], mdlMem[i]);
         end
         checkEq("err", err, expErr);
      end
      testsRun++;
      if (errors != errBefore) begin
         testsFailed++;
      end
      $display("Test %0d %s: %s", testsRun, name, (errors == errBefore) ? "ok" : "failed");
   endtask

   initial begin
      rstN        = 1'b0;
      dmemDone    = 1'b0;
      dmemRdata   = '0;
      waitLeft    = -1;
      errors      = 0;
      checks      = 0;
      testsRun    = 0;
      testsFailed = 0;
      timedOut    = 1'b0;
      runTest("arithmetic forwarding", 0, 48);
      if (!timedOut) begin
         runTest("loads and stores", 1, 48);
      end
      if (!timedOut) begin
         runTest("branches", 2, 48);
      end
      if (!timedOut) begin
         runTest("mixed program and halt", 3, 40);
      end
      if (!timedOut) begin
         runTest("illegal opcode", 4, 40);
      end
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               testsRun, testsFailed, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
rtl/procPkg.sv
rtl/regFile.sv
rtl/fetch.sv
rtl/decode.sv
rtl/hazardCtrl.sv
rtl/execute.sv
rtl/memStage.sv
rtl/proc.sv
tests/tbProc.sv

//--- Bender.yml
package:
  name: proc

dependencies: {}

sources:
  - files:
      - rtl/procPkg.sv
      - rtl/regFile.sv
      - rtl/fetch.sv
      - rtl/decode.sv
      - rtl/hazardCtrl.sv
      - rtl/execute.sv
      - rtl/memStage.sv
      - rtl/proc.sv
  - target: test
    files:
      - tests/tbProc.sv
